//--- design/sync_adjust_pkg.sv
// shared widths, fixed-point fractions and filter gains, imported by every sync adjust module
`default_nettype none

package sync_adjust_pkg;

    // --------------------
    // base widths
    // --------------------
    localparam int unsigned TIMER_WIDTH    = 32;
    localparam int unsigned CYCLE_WIDTH    = 32; // raw cycle counter
    localparam int unsigned ERROR_WIDTH    = 32; // integer part of phase error
    localparam int unsigned ERROR_Q        = 8;
    localparam int unsigned ADJUST_Q       = ERROR_Q;
    localparam int unsigned ADJUST_WIDTH   = CYCLE_WIDTH + ERROR_Q;

    // filter update gains, 1/2^N
    localparam int unsigned LPF_GAIN_CYCLE = 6;
    localparam int unsigned LPF_GAIN_PHASE = 6;

    // --------------------
    // derived widths
    // --------------------
    localparam int unsigned CYCLE_Q        = LPF_GAIN_CYCLE;
    localparam int unsigned CYCLE_EST_BITS = CYCLE_WIDTH + CYCLE_Q;
    localparam int unsigned ERROR_BITS     = ERROR_WIDTH + ERROR_Q;   // signed
    localparam int unsigned INTERVAL_BITS  = ADJUST_WIDTH + ADJUST_Q;
    localparam int unsigned DIVIDEND_BITS  = CYCLE_WIDTH + ERROR_Q + ADJUST_Q;
    localparam int unsigned DIV_ALIGN      = ERROR_Q + ADJUST_Q - CYCLE_Q;
    localparam int unsigned DIV_COUNT_BITS = $clog2(DIVIDEND_BITS + 1);

    // one whole clock in interval fixed point
    localparam logic [INTERVAL_BITS-1:0] ADJ_STEP = INTERVAL_BITS'(1) << ADJUST_Q;

    localparam int unsigned STAGE_COUNT    = 4; // phase estimator stages

endpackage

`default_nettype wire

//--- design/adjust_sequencer.sv
// stage sequencer, turns each correction strobe into a one-hot run of phase estimator strobes
`default_nettype none

module adjust_sequencer import sync_adjust_pkg::*; (
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    correct_valid,
    input  wire                    correct_override,
    output logic [STAGE_COUNT-1:0] stage_strobe,
    output logic                   override_hold
);

    // stage k fires k+1 cycles after the correction
    always_ff @(posedge clk) begin
        if (reset) begin
            stage_strobe  <= '0;
            override_hold <= 1'b0;
        end else begin
            stage_strobe <= {stage_strobe[STAGE_COUNT-2:0], correct_valid};
            if (correct_valid) begin
                override_hold <= correct_override; // kept until next correction
            end
        end
    end

endmodule

`default_nettype wire

//--- design/cycle_estimator.sv
// local cycles per correction period, counted and smoothed by a first-order low-pass filter
`default_nettype none

module cycle_estimator import sync_adjust_pkg::*; (
    input  wire                       clk,
    input  wire                       reset,
    input  wire                       correct_valid,
    output logic [CYCLE_EST_BITS-1:0] cycle_estimate,
    output logic                      cycle_estimate_valid
);

    logic [CYCLE_WIDTH-1:0]    count;
    logic                      count_enable;
    logic                      observe_pending;
    logic [CYCLE_EST_BITS-1:0] observe;

    always_ff @(posedge clk) begin
        if (reset) begin
            count_enable         <= 1'b0;
            observe_pending      <= 1'b0;
            cycle_estimate_valid <= 1'b0;
        end else begin
            if (correct_valid) begin
                count_enable <= 1'b1; // first correction only starts the count
            end
            observe_pending <= correct_valid & count_enable;
            if (observe_pending) begin
                cycle_estimate_valid <= 1'b1;
            end
        end
    end

    // --------------------
    // count and filter
    // --------------------
    always_ff @(posedge clk) begin
        count <= correct_valid ? CYCLE_WIDTH'(1) : count + CYCLE_WIDTH'(1);
        if (correct_valid & count_enable) begin
            observe <= CYCLE_EST_BITS'(count) << CYCLE_Q;
        end
        if (observe_pending) begin
            if (cycle_estimate_valid) begin
                cycle_estimate <= cycle_estimate - (cycle_estimate >> LPF_GAIN_CYCLE)
                                + (observe >> LPF_GAIN_CYCLE);
            end else begin
                cycle_estimate <= observe; // first observation taken as is
            end
        end
    end

endmodule

`default_nettype wire

//--- design/phase_estimator.sv
// phase error estimator, predicts, filters and clamps the error to give the adjust amount
`default_nettype none

module phase_estimator import sync_adjust_pkg::*; (
    input  wire                           clk,
    input  wire                           reset,
    input  wire                           correct_valid,
    input  wire                           correct_override,
    input  wire        [TIMER_WIDTH-1:0]  correct_time,
    input  wire        [TIMER_WIDTH-1:0]  current_time,
    input  wire signed [ERROR_WIDTH-1:0]  param_adjust_min,
    input  wire signed [ERROR_WIDTH-1:0]  param_adjust_max,
    input  wire        [STAGE_COUNT-1:0]  stage_strobe,
    output logic signed [ERROR_BITS-1:0]  adjust_value,
    output logic                          adjust_zero,
    output logic                          adjust_neg,
    output logic                          error_valid
);

    logic signed [ERROR_BITS-1:0] current_error;
    logic signed [ERROR_BITS-1:0] limit_min;
    logic signed [ERROR_BITS-1:0] limit_max;
    logic signed [ERROR_BITS-1:0] observe;
    logic signed [ERROR_BITS-1:0] estimate_prev;
    logic signed [ERROR_BITS-1:0] predict;
    logic signed [ERROR_BITS-1:0] predict_gain;
    logic signed [ERROR_BITS-1:0] estimate;
    logic signed [ERROR_BITS-1:0] clamped;
    logic                         prev_en;
    logic                         predict_en;
    logic                         gain_en;
    logic                         estimate_en;

    // reference ahead of local time gives a positive error
    assign current_error = ERROR_BITS'($signed(correct_time - current_time)) <<< ERROR_Q;
    assign limit_min     = ERROR_BITS'(param_adjust_min) <<< ERROR_Q;
    assign limit_max     = ERROR_BITS'(param_adjust_max) <<< ERROR_Q;

    assign clamped = (estimate < limit_min) ? limit_min :
                     (estimate > limit_max) ? limit_max : estimate;

    always_ff @(posedge clk) begin
        if (reset) begin
            prev_en      <= 1'b0;
            predict_en   <= 1'b0;
            gain_en      <= 1'b0;
            estimate_en  <= 1'b0;
            adjust_value <= '0;
            adjust_zero  <= 1'b1;
            adjust_neg   <= 1'b0;
            error_valid  <= 1'b0;
        end else begin
            if (correct_valid) begin
                if (correct_override) begin
                    // restart the filter from scratch
                    prev_en     <= 1'b0;
                    predict_en  <= 1'b0;
                    gain_en     <= 1'b0;
                    estimate_en <= 1'b0;
                end else begin
                    prev_en <= estimate_en;
                end
            end
            if (stage_strobe[0]) predict_en <= prev_en;
            if (stage_strobe[1]) gain_en <= predict_en;
            if (stage_strobe[2]) estimate_en <= 1'b1;
            if (stage_strobe[3]) begin
                adjust_value <= clamped;
                adjust_zero  <= (clamped == '0);
                adjust_neg   <= (clamped < 0);
            end
            error_valid <= stage_strobe[3];
        end
    end

    // --------------------
    // filter datapath
    // --------------------
    always_ff @(posedge clk) begin
        if (correct_valid) begin
            observe       <= correct_override ? '0 : current_error;
            estimate_prev <= estimate;
        end
        if (stage_strobe[0]) predict <= estimate_prev - adjust_value; // minus what was applied
        if (stage_strobe[1]) predict_gain <= predict - (predict >>> LPF_GAIN_PHASE);
        if (stage_strobe[2]) begin
            estimate <= gain_en ? predict_gain + (observe >>> LPF_GAIN_PHASE) : observe;
        end
    end

endmodule

`default_nettype wire

//--- design/interval_divider.sv
// multicycle restoring divider, cycle estimate over error magnitude gives the pulse interval
`default_nettype none

module interval_divider import sync_adjust_pkg::*; (
    input  wire                          clk,
    input  wire                          reset,
    input  wire                          div_start,
    input  wire        [CYCLE_EST_BITS-1:0] cycle_estimate,
    input  wire signed [ERROR_BITS-1:0]  adjust_value,
    input  wire                          adjust_zero,
    input  wire                          adjust_neg,
    output logic [INTERVAL_BITS-1:0]     quotient,
    output logic                         div_zero,
    output logic                         div_sign,
    output logic                         div_valid
);

    logic [ERROR_BITS-1:0]     divisor;
    logic [ERROR_BITS-1:0]     remainder;
    logic [ERROR_BITS:0]       trial;
    logic [ERROR_BITS:0]       difference;
    logic [DIV_COUNT_BITS-1:0] bit_count;
    logic                      busy;

    // dividend shifts out of quotient as result bits shift in
    assign trial      = {remainder, quotient[INTERVAL_BITS-1]};
    assign difference = trial - {1'b0, divisor};

    always_ff @(posedge clk) begin
        if (reset) begin
            busy      <= 1'b0;
            div_valid <= 1'b0;
        end else begin
            div_valid <= 1'b0;
            if (div_start) begin
                busy <= 1'b1;
            end else if (busy && bit_count == DIV_COUNT_BITS'(1)) begin
                busy      <= 1'b0;
                div_valid <= 1'b1;
            end
        end
    end

    // --------------------
    // one bit per cycle
    // --------------------
    always_ff @(posedge clk) begin
        if (div_start) begin
            divisor   <= adjust_neg ? $unsigned(-adjust_value) : $unsigned(adjust_value);
            remainder <= '0;
            quotient  <= INTERVAL_BITS'(cycle_estimate) << DIV_ALIGN; // to Q of error+adjust
            bit_count <= DIV_COUNT_BITS'(DIVIDEND_BITS);
            div_zero  <= adjust_zero;
            div_sign  <= adjust_neg;
        end else if (busy) begin
            bit_count <= bit_count - DIV_COUNT_BITS'(1);
            if (difference[ERROR_BITS]) begin // borrow, restore
                remainder <= trial[ERROR_BITS-1:0];
                quotient  <= {quotient[INTERVAL_BITS-2:0], 1'b0};
            end else begin
                remainder <= difference[ERROR_BITS-1:0];
                quotient  <= {quotient[INTERVAL_BITS-2:0], 1'b1};
            end
        end
    end

endmodule

`default_nettype wire

//--- design/adjust_pulse_gen.sv
// adjust pulse pacing, holds the interval, fires single-tick pulses and drives the handshake
`default_nettype none

module adjust_pulse_gen import sync_adjust_pkg::*; (
    input  wire                      clk,
    input  wire                      reset,
    input  wire [INTERVAL_BITS-1:0]  quotient,
    input  wire                      div_zero,
    input  wire                      div_sign,
    input  wire                      div_valid,
    input  wire                      adjust_ready,
    output logic                     adjust_sign,
    output logic                     adjust_valid
);

    logic [INTERVAL_BITS-1:0] new_period;
    logic                     param_zero;
    logic                     param_sign;
    logic [INTERVAL_BITS-1:0] param_period;
    logic                     param_valid;
    logic                     calc_zero;
    logic                     calc_sign;
    logic [INTERVAL_BITS-1:0] calc_period;
    logic [INTERVAL_BITS-1:0] calc_count;
    logic [INTERVAL_BITS-1:0] calc_next;
    logic                     calc_valid;

    assign new_period = quotient - ADJ_STEP;

    // --------------------
    // pending parameters
    // --------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            param_zero  <= 1'b1;
            param_valid <= 1'b0;
        end else begin
            if (calc_valid) param_valid <= 1'b0; // taken in this slot
            if (div_valid) begin
                if (div_zero) begin
                    param_zero  <= 1'b1;
                    param_valid <= !param_zero;
                end else begin
                    param_zero   <= 1'b0;
                    param_sign   <= div_sign;
                    param_period <= new_period;
                    param_valid  <= param_zero || (new_period != param_period);
                end
            end
        end
    end

    // --------------------
    // fractional pacing
    // --------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            calc_zero   <= 1'b1;
            calc_period <= '0;
            calc_count  <= '0;
            calc_valid  <= 1'b0;
        end else begin
            calc_count <= calc_count + ADJ_STEP;
            calc_next  <= calc_count + ADJ_STEP - calc_period; // carry the remainder
            calc_valid <= (calc_count >= calc_period) || calc_zero;
            if (calc_valid) begin
                if (param_valid) begin
                    calc_zero   <= param_zero;
                    calc_sign   <= param_sign;
                    calc_period <= param_period;
                    calc_count  <= '0;
                end else begin
                    calc_count <= calc_next;
                end
                calc_valid <= 1'b0;
            end
        end
    end

    // pulses merge into an unacknowledged one
    always_ff @(posedge clk) begin
        if (reset) begin
            adjust_valid <= 1'b0;
        end else begin
            if (adjust_ready) adjust_valid <= 1'b0;
            if (calc_valid && !calc_zero) begin
                adjust_sign  <= calc_sign;
                adjust_valid <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/sync_adjust_top.sv
// top level of the timer adjuster, links the sequencer to the estimator and pulse datapath
`default_nettype none

module sync_adjust_top import sync_adjust_pkg::*; (
    input  wire                          clk,
    input  wire                          reset,
    input  wire signed [ERROR_WIDTH-1:0] param_adjust_min,
    input  wire signed [ERROR_WIDTH-1:0] param_adjust_max,
    input  wire        [TIMER_WIDTH-1:0] current_time,
    input  wire        [TIMER_WIDTH-1:0] correct_time,
    input  wire                          correct_override,
    input  wire                          correct_valid,
    output logic                         adjust_sign,
    output logic                         adjust_valid,
    input  wire                          adjust_ready
);

    logic [STAGE_COUNT-1:0]       stage_strobe;
    logic                         override_hold;
    logic [CYCLE_EST_BITS-1:0]    cycle_estimate;
    logic                         cycle_estimate_valid;
    logic signed [ERROR_BITS-1:0] adjust_value;
    logic                         adjust_zero;
    logic                         adjust_neg;
    logic                         error_valid;
    logic                         div_start;
    logic [INTERVAL_BITS-1:0]     quotient;
    logic                         div_zero;
    logic                         div_sign;
    logic                         div_valid;

    // no interval without a cycle estimate, none after an override
    assign div_start = error_valid & cycle_estimate_valid & ~override_hold;

    adjust_sequencer sequencer0 (
        .clk              (clk),
        .reset            (reset),
        .correct_valid    (correct_valid),
        .correct_override (correct_override),
        .stage_strobe     (stage_strobe),
        .override_hold    (override_hold)
    );

    cycle_estimator cycle0 (
        .clk                  (clk),
        .reset                (reset),
        .correct_valid        (correct_valid),
        .cycle_estimate       (cycle_estimate),
        .cycle_estimate_valid (cycle_estimate_valid)
    );

    phase_estimator phase0 (
        .clk              (clk),
        .reset            (reset),
        .correct_valid    (correct_valid),
        .correct_override (correct_override),
        .correct_time     (correct_time),
        .current_time     (current_time),
        .param_adjust_min (param_adjust_min),
        .param_adjust_max (param_adjust_max),
        .stage_strobe     (stage_strobe),
        .adjust_value     (adjust_value),
        .adjust_zero      (adjust_zero),
        .adjust_neg       (adjust_neg),
        .error_valid      (error_valid)
    );

    interval_divider divider0 (
        .clk            (clk),
        .reset          (reset),
        .div_start      (div_start),
        .cycle_estimate (cycle_estimate),
        .adjust_value   (adjust_value),
        .adjust_zero    (adjust_zero),
        .adjust_neg     (adjust_neg),
        .quotient       (quotient),
        .div_zero       (div_zero),
        .div_sign       (div_sign),
        .div_valid      (div_valid)
    );

    adjust_pulse_gen pulse0 (
        .clk          (clk),
        .reset        (reset),
        .quotient     (quotient),
        .div_zero     (div_zero),
        .div_sign     (div_sign),
        .div_valid    (div_valid),
        .adjust_ready (adjust_ready),
        .adjust_sign  (adjust_sign),
        .adjust_valid (adjust_valid)
    );

endmodule

`default_nettype wire

//--- verification/tb_clock.sv
// testbench clock and power-on reset, 10 unit period with reset held for the first 16 cycles
`default_nettype none

module tb_clock (
    output logic clk,
    output logic reset
);

    initial begin
        clk   = 1'b0;
        reset = 1'b1;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
    end

    always #5 clk = ~clk;

endmodule

`default_nettype wire

//--- verification/sync_adjust_tb.sv
// testbench for the sync adjuster, runs a table of correction cases and checks the adjust pulses
`default_nettype none

module sync_adjust_tb import sync_adjust_pkg::*; ();

    localparam int NUM_CASES          = 5;
    localparam int SETTLE_CORRECTIONS = 8;
    localparam int WINDOW_PERIODS     = 4;
    localparam int IDLE_CYCLES        = 2000;
    localparam int WAIT_LIMIT         = 1000;

    logic                          clk;
    logic                          reset;
    logic signed [ERROR_WIDTH-1:0] param_adjust_min;
    logic signed [ERROR_WIDTH-1:0] param_adjust_max;
    logic        [TIMER_WIDTH-1:0] current_time;
    logic        [TIMER_WIDTH-1:0] correct_time;
    logic                          correct_override;
    logic                          correct_valid;
    logic                          adjust_sign;
    logic                          adjust_valid;
    logic                          adjust_ready;

    // stimulus table, one row per case
    string case_name     [NUM_CASES];
    int    case_period   [NUM_CASES]; // 0 means no corrections
    int    case_offset   [NUM_CASES];
    bit    case_override [NUM_CASES];
    int    case_limit    [NUM_CASES];
    bit    case_sign     [NUM_CASES];
    int    case_spacing  [NUM_CASES]; // 0 means no pulses

    int seed;
    int check_count;
    int error_count;
    int cycle;
    int idx;
    int n;

    // pulse monitor state
    bit watch;
    bit valid_prev;
    bit have_rise;
    int last_rise;
    int gap;
    int gap_min;
    int gap_max;
    int pulse_count;
    int sign_ones;

    tb_clock clock0 (
        .clk   (clk),
        .reset (reset)
    );

    sync_adjust_top dut0 (
        .clk              (clk),
        .reset            (reset),
        .param_adjust_min (param_adjust_min),
        .param_adjust_max (param_adjust_max),
        .current_time     (current_time),
        .correct_time     (correct_time),
        .correct_override (correct_override),
        .correct_valid    (correct_valid),
        .adjust_sign      (adjust_sign),
        .adjust_valid     (adjust_valid),
        .adjust_ready     (adjust_ready)
    );

    always @(posedge clk) begin
        current_time <= current_time + 1; // free-running local timer
        cycle        <= cycle + 1;
    end

    // --------------------
    // pulse monitor
    // --------------------
    always @(negedge clk) begin
        if (watch && adjust_valid && !valid_prev) begin
            if (have_rise) begin
                gap = cycle - last_rise;
                if (gap < gap_min) gap_min = gap;
                if (gap > gap_max) gap_max = gap;
            end
            have_rise   = 1'b1;
            last_rise   = cycle;
            pulse_count = pulse_count + 1;
            if (adjust_sign) sign_ones = sign_ones + 1;
        end
        valid_prev = adjust_valid;
    end

    task check_value(input string case_id, input string what, input int expected,
                     input int actual, input int tolerance);
        begin
            check_count = check_count + 1;
            if (actual < expected - tolerance || actual > expected + tolerance) begin
                error_count = error_count + 1;
                $display("ERROR %s %s: expected %0d, actual %0d", case_id, what, expected, actual);
            end
        end
    endtask

    task set_row(input int i, input string name, input int period, input int offset,
                 input bit override, input int limit, input bit sign);
        begin
            case_name[i]     = name;
            case_period[i]   = period;
            case_offset[i]   = offset;
            case_override[i] = override;
            case_limit[i]    = limit;
            case_sign[i]     = sign;
            case_spacing[i]  = 0;
        end
    endtask

    task fill_table();
        int k;
        int period;
        begin
            k = $random(seed) % 21;
            if (k < 0) k = -k;
            period = 40 * (5 + k); // 200 to 1000, multiple of every limit
            set_row(0, "idle",          0,      0,     1'b0, 20, 1'b0);
            set_row(1, "override_zero", period, 0,     1'b1, 20, 1'b0);
            set_row(2, "advance",       period, 5000,  1'b1, 20, 1'b0);
            set_row(3, "slow",          period, -5000, 1'b1, 40, 1'b1);
            set_row(4, "clamp",         period, 20000, 1'b1, 10, 1'b0);
            // offsets exceed 64x the limit, so the error stays clamped
            for (k = 2; k < NUM_CASES; k = k + 1) begin
                case_spacing[k] = period / case_limit[k];
            end
        end
    endtask

    // one correction, then the rest of its period
    task run_period(input int period, input int offset, input bit override, input int limit);
        int i;
        begin
            @(posedge clk);
            correct_time     <= current_time + 1 + offset;
            correct_override <= override;
            correct_valid    <= 1'b1;
            param_adjust_min <= -limit;
            param_adjust_max <= limit;
            @(posedge clk);
            correct_valid    <= 1'b0;
            correct_override <= 1'b0;
            for (i = 2; i < period; i = i + 1) begin
                @(posedge clk);
            end
        end
    endtask

    task open_window();
        begin
            have_rise   = 1'b0;
            gap_min     = 32'h7fff_ffff;
            gap_max     = 0;
            pulse_count = 0;
            sign_ones   = 0;
            watch       = 1'b1;
        end
    endtask

    task apply_case(input int i);
        int j;
        begin
            if (case_period[i] == 0) begin
                open_window();
                repeat (IDLE_CYCLES) @(posedge clk);
            end else begin
                for (j = 0; j < SETTLE_CORRECTIONS; j = j + 1) begin
                    run_period(case_period[i], case_offset[i], case_override[i] && j == 0,
                               case_limit[i]);
                end
                open_window();
                for (j = 0; j < WINDOW_PERIODS; j = j + 1) begin
                    run_period(case_period[i], case_offset[i], 1'b0, case_limit[i]);
                end
            end
            watch = 1'b0;
            if (case_spacing[i] == 0) begin
                check_value(case_name[i], "pulse count", 0, pulse_count, 0);
            end else begin
                check_value(case_name[i], "pulse count",
                            WINDOW_PERIODS * case_period[i] / case_spacing[i], pulse_count, 1);
                check_value(case_name[i], "pulses with wrong sign", 0,
                            case_sign[i] ? pulse_count - sign_ones : sign_ones, 0);
                check_value(case_name[i], "min spacing", case_spacing[i], gap_min, 1);
                check_value(case_name[i], "max spacing", case_spacing[i], gap_max, 1);
            end
        end
    endtask

    // valid must hold through stalled slots and clear one cycle after ready
    task check_back_pressure(input int spacing);
        int i;
        int lows;
        bit found;
        begin
            found = 1'b0;
            lows  = 0;
            @(posedge clk);
            adjust_ready <= 1'b0;
            for (i = 0; i < WAIT_LIMIT && !found; i = i + 1) begin
                @(negedge clk);
                if (adjust_valid) found = 1'b1;
            end
            if (!found) begin
                error_count = error_count + 1;
                $display("timed out waiting for an adjust pulse while adjust_ready was low");
            end else begin
                for (i = 0; i < 2 * spacing + spacing / 2; i = i + 1) begin
                    @(negedge clk);
                    if (!adjust_valid) lows = lows + 1;
                end
                check_value("back_pressure", "cycles with valid low", 0, lows, 0);
                @(posedge clk);
                adjust_ready <= 1'b1;
                @(negedge clk);
                check_value("back_pressure", "valid as ready rises", 1, adjust_valid, 0);
                @(negedge clk);
                check_value("back_pressure", "valid after ready", 0, adjust_valid, 0);
            end
        end
    endtask

    initial begin
        param_adjust_min = '0;
        param_adjust_max = '0;
        current_time     = '0;
        correct_time     = '0;
        correct_override = 1'b0;
        correct_valid    = 1'b0;
        adjust_ready     = 1'b1;
        cycle            = 0;
        watch            = 1'b0;
        valid_prev       = 1'b0;
        check_count      = 0;
        error_count      = 0;
        seed             = 32'h2b8f;
        fill_table();

        n = 0;
        @(negedge clk);
        while (reset && n < 100) begin
            @(negedge clk);
            n = n + 1;
        end
        if (reset) begin
            error_count = error_count + 1;
            $display("reset was never released");
        end else begin
            for (idx = 0; idx < NUM_CASES; idx = idx + 1) begin
                apply_case(idx);
            end
            check_back_pressure(case_spacing[NUM_CASES-1]);
        end

        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
design/sync_adjust_pkg.sv
design/adjust_sequencer.sv
design/cycle_estimator.sv
design/phase_estimator.sv
design/interval_divider.sv
design/adjust_pulse_gen.sv
design/sync_adjust_top.sv
verification/tb_clock.sv
verification/sync_adjust_tb.sv
